//--- all.f
+incdir+source
source/wd_pkg.sv
source/wd_rr_arb.sv
source/cq_watchdog.sv
source/wd_irq_report.sv
source/chp_wd_top.sv
verif/wd_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# Build the watchdog testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

//--- verif/tb_top.sv
`timescale 1ns/100ps
`include "wd_params.svh"

module tb_top;

  import wd_pkg::*;

  localparam int NQ    = 1 << `WD_CQ_IDX_W;
  localparam int DIR_N = `WD_DIR_NUM_CQ;
  localparam int LDB_N = `WD_LDB_NUM_CQ;

  logic             hqm_gated_clk;
  logic             hqm_gated_rst_n;
  wd_cfg_t          dir_cfg;
  logic             dir_cfg_update_v;
  logic [DIR_N-1:0] dir_en;
  logic [DIR_N-1:0] dir_busy;
  cq_event_t        dir_excep;
  logic [DIR_N-1:0] dir_irq;
  logic             dir_wdto_v;
  logic [DIR_N-1:0] dir_wdto_nxt;
  wd_cfg_t          ldb_cfg;
  logic             ldb_cfg_update_v;
  logic [LDB_N-1:0] ldb_en;
  logic [LDB_N-1:0] ldb_busy;
  cq_event_t        ldb_excep;
  logic [LDB_N-1:0] ldb_irq;
  logic             ldb_wdto_v;
  logic [LDB_N-1:0] ldb_wdto_nxt;
  logic             req_ready;
  logic             req_valid;
  cwdi_req_t        req;

  logic [15:0]      lfsr;
  bit               bp_mode;      // Ready toggles at random when set
  int unsigned      test_cnt = 0;
  int unsigned      fail_cnt = 0;
  int unsigned      timeout_cnt = 0;

  initial begin
    hqm_gated_clk = 1'b0;
    forever #5 hqm_gated_clk = ~hqm_gated_clk;
  end

  chp_wd_top dut_i (
     .hqm_gated_clk (hqm_gated_clk), .hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_dir_cfg (dir_cfg), .i_dir_cfg_update_v (dir_cfg_update_v)
    ,.i_dir_cq_wd_en (dir_en), .i_dir_cq_busy (dir_busy), .i_dir_excep (dir_excep)
    ,.o_dir_wd_irq (dir_irq), .o_dir_wdto_v (dir_wdto_v), .o_dir_wdto_nxt (dir_wdto_nxt)
    ,.i_ldb_cfg (ldb_cfg), .i_ldb_cfg_update_v (ldb_cfg_update_v)
    ,.i_ldb_cq_wd_en (ldb_en), .i_ldb_cq_busy (ldb_busy), .i_ldb_excep (ldb_excep)
    ,.o_ldb_wd_irq (ldb_irq), .o_ldb_wdto_v (ldb_wdto_v), .o_ldb_wdto_nxt (ldb_wdto_nxt)
    ,.i_req_ready (req_ready), .o_req_valid (req_valid), .o_req (req)
  );

  wd_checker chk_i (
     .hqm_gated_clk (hqm_gated_clk), .hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_dir_wd_irq (dir_irq), .i_dir_wdto_v (dir_wdto_v), .i_dir_wdto_nxt (dir_wdto_nxt)
    ,.i_ldb_wd_irq (ldb_irq), .i_ldb_wdto_v (ldb_wdto_v), .i_ldb_wdto_nxt (ldb_wdto_nxt)
    ,.i_req_ready (req_ready), .i_req_valid (req_valid), .i_req (req)
  );

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge hqm_gated_clk);
    #1;
    if (bp_mode) begin
      draw(1, r);
      req_ready = r[0];
    end
  endtask

  task automatic end_test(input string name, input int unsigned errs, input int unsigned tmos);
    test_cnt++;
    if (chk_i.err_cnt != errs || timeout_cnt != tmos) begin
      fail_cnt++;
      $display("test %0d %s: failed", test_cnt, name);
    end else begin
      $display("test %0d %s: ok", test_cnt, name);
    end
  endtask

  // ----------------------------------------------------------------------
  // Mode 0 random, 1 activity and enable, 2 back-pressure, 3 fairness
  // ----------------------------------------------------------------------
  task automatic run_scenario(input string name, input int mode);
    logic [31:0]   r;
    wd_cfg_t       cfg;
    logic [NQ-1:0] dir_act;
    logic [NQ-1:0] ldb_act;
    int unsigned   tmo;
    int unsigned   n;
    int unsigned   errs;
    int unsigned   tmos;
    errs = chk_i.err_cnt;
    tmos = timeout_cnt;
    draw(2, r);
    cfg.interval  = `WD_INTERVAL_W'(r[1:0]) + ((mode == 1) ? 2 : (mode == 2) ? 6 : 4);
    draw(2, r);
    cfg.threshold = `WD_THRESHOLD_W'(r[1:0]) + ((mode == 1) ? 3 : (mode == 2) ? 20 : 12);
    draw(DIR_N, r);
    dir_en = DIR_N'(r);
    draw(DIR_N, r);
    dir_busy = DIR_N'(r);
    draw(LDB_N, r);
    ldb_en = LDB_N'(r);
    draw(LDB_N, r);
    ldb_busy = LDB_N'(r);
    dir_act = '0;
    ldb_act = '0;
    if (mode == 3) begin  // Every CQ fires together
      dir_en   = '1;
      dir_busy = '1;
      ldb_en   = '1;
      ldb_busy = '1;
    end
    if (mode == 1) begin
      draw(3, r);
      dir_excep.cq = `WD_CQ_IDX_W'(r[2:0]);
      draw(4, r);
      ldb_excep.cq = `WD_CQ_IDX_W'(r[3:0]);
      dir_excep.v = 1'b1;  // Held high, so activity every cycle
      ldb_excep.v = 1'b1;
      dir_en[dir_excep.cq]   = 1'b1;
      dir_busy[dir_excep.cq] = 1'b1;
      ldb_en[ldb_excep.cq]   = 1'b1;
      ldb_busy[ldb_excep.cq] = 1'b1;
      dir_act = NQ'(1) << dir_excep.cq;
      ldb_act = NQ'(1) << ldb_excep.cq;
    end
    dir_cfg          = cfg;
    ldb_cfg          = cfg;
    dir_cfg_update_v = 1'b1;
    ldb_cfg_update_v = 1'b1;
    bp_mode = (mode == 2);
    chk_i.start_window(NQ'(dir_en), NQ'(dir_busy), dir_act, NQ'(ldb_en), NQ'(ldb_busy), ldb_act);
    next_cycle();
    dir_cfg_update_v = 1'b0;
    ldb_cfg_update_v = 1'b0;
    tmo = (cfg.interval + 1) * (cfg.threshold + 2) + 64;
    if (mode == 1) begin
      repeat (3 * tmo) next_cycle();  // Observation window
    end else begin
      n = 0;
      while (!chk_i.all_reported() && n < tmo) begin
        next_cycle();
        n++;
      end
      if (!chk_i.all_reported()) begin
        timeout_cnt++;
        $display("Timeout: not every expected CQ reported within %0d cycles", tmo);
      end
    end
    // Quiet all CQs and let the pending reports drain
    dir_en    = '0;
    ldb_en    = '0;
    dir_excep = '0;
    ldb_excep = '0;
    n = 0;
    while ((req_valid || dir_irq != '0 || ldb_irq != '0) && n < tmo) begin
      next_cycle();
      n++;
    end
    if (req_valid || dir_irq != '0 || ldb_irq != '0) begin
      timeout_cnt++;
      $display("Timeout: pending reports did not drain within %0d cycles", tmo);
    end
    bp_mode   = 1'b0;
    req_ready = 1'b1;
    chk_i.compare_reports(mode != 1);
    end_test(name, errs, tmos);
  endtask

  initial begin
    lfsr             = 16'd40299;
    bp_mode          = 1'b0;
    hqm_gated_rst_n  = 1'b0;
    dir_cfg          = '0;
    dir_cfg_update_v = 1'b0;
    dir_en           = '0;
    dir_busy         = '0;
    dir_excep        = '0;
    ldb_cfg          = '0;
    ldb_cfg_update_v = 1'b0;
    ldb_en           = '0;
    ldb_busy         = '0;
    ldb_excep        = '0;
    req_ready        = 1'b1;
    repeat (3) @(posedge hqm_gated_clk);
    #1;
    hqm_gated_rst_n = 1'b1;
    @(negedge hqm_gated_clk);
    chk_i.check_reset_state();
    end_test("reset state", 0, 0);
    next_cycle();
    run_scenario("random config", 0);
    run_scenario("activity and enable", 1);
    run_scenario("back-pressure", 2);
    run_scenario("fairness", 3);
    $display("tests %0d, failed %0d, errors %0d, timeouts %0d",
             test_cnt, fail_cnt, chk_i.err_cnt, timeout_cnt);
    if (fail_cnt == 0 && chk_i.err_cnt == 0 && timeout_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verif/wd_checker.sv
`timescale 1ns/100ps
`include "wd_params.svh"

module wd_checker (
   input  logic                      hqm_gated_clk
  ,input  logic                      hqm_gated_rst_n
  ,input  logic [`WD_DIR_NUM_CQ-1:0] i_dir_wd_irq
  ,input  logic                      i_dir_wdto_v
  ,input  logic [`WD_DIR_NUM_CQ-1:0] i_dir_wdto_nxt
  ,input  logic [`WD_LDB_NUM_CQ-1:0] i_ldb_wd_irq
  ,input  logic                      i_ldb_wdto_v
  ,input  logic [`WD_LDB_NUM_CQ-1:0] i_ldb_wdto_nxt
  ,input  logic                      i_req_ready
  ,input  logic                      i_req_valid
  ,input  wd_pkg::cwdi_req_t         i_req
);

  import wd_pkg::*;

  localparam int NQ = 1 << `WD_CQ_IDX_W;

  int unsigned   err_cnt = 0;
  int unsigned   dir_cnt [NQ];   // Transfers per CQ in the current window
  int unsigned   ldb_cnt [NQ];
  logic [NQ-1:0] exp_dir = '0;
  logic [NQ-1:0] exp_ldb = '0;
  logic          prev_stall = 1'b0;
  logic          prev_fair = 1'b0;   // Transfer seen while both classes were pending
  cwdi_req_t     prev_req;

  // A CQ must report when enabled, busy and quiet
  function automatic logic [NQ-1:0] expected_fire(input logic [NQ-1:0] en,
                                                  input logic [NQ-1:0] busy,
                                                  input logic [NQ-1:0] act);
    return en & busy & ~act;
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    err_cnt++;
    $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic plain_error(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic start_window(input logic [NQ-1:0] dir_en, input logic [NQ-1:0] dir_busy,
                              input logic [NQ-1:0] dir_act, input logic [NQ-1:0] ldb_en,
                              input logic [NQ-1:0] ldb_busy, input logic [NQ-1:0] ldb_act);
    exp_dir = expected_fire(dir_en, dir_busy, dir_act);
    exp_ldb = expected_fire(ldb_en, ldb_busy, ldb_act);
    for (int i = 0; i < NQ; i++) begin
      dir_cnt[i] = 0;
      ldb_cnt[i] = 0;
    end
  endtask

  function automatic bit all_reported();
    for (int i = 0; i < NQ; i++) begin
      if ((exp_dir[i] && dir_cnt[i] == 0) || (exp_ldb[i] && ldb_cnt[i] == 0)) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_reset_state();
    if (i_req_valid !== 1'b0)   value_error("o_req_valid", i_req_valid, 0);
    if (i_dir_wdto_v !== 1'b0)  value_error("o_dir_wdto_v", i_dir_wdto_v, 0);
    if (i_ldb_wdto_v !== 1'b0)  value_error("o_ldb_wdto_v", i_ldb_wdto_v, 0);
    if (i_dir_wd_irq !== '0)    value_error("o_dir_wd_irq", i_dir_wd_irq, 0);
    if (i_ldb_wd_irq !== '0)    value_error("o_ldb_wd_irq", i_ldb_wd_irq, 0);
  endtask

  task automatic check_count(input string cls, input int cq, input logic exp,
                             input int unsigned n, input bit exact);
    if (!exp && n != 0) begin
      plain_error($sformatf("%s CQ %0d reported %0d times but must stay quiet", cls, cq, n));
    end else if (exp && n == 0) begin
      plain_error($sformatf("%s CQ %0d never reported", cls, cq));
    end else if (exp && exact && n != 1) begin
      plain_error($sformatf("%s CQ %0d reported %0d times instead of once", cls, cq, n));
    end
  endtask

  task automatic compare_reports(input bit exact);
    for (int i = 0; i < NQ; i++) begin
      check_count("dir", i, exp_dir[i], dir_cnt[i], exact);
      check_count("ldb", i, exp_ldb[i], ldb_cnt[i], exact);
    end
  endtask

  // ----------------------------------------------------------------------
  // Per-cycle monitor sampled mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge hqm_gated_clk) begin
    logic [NQ-1:0] onehot;
    logic          both;
    logic          xfer;
    if (!hqm_gated_rst_n) begin
      prev_stall = 1'b0;
      prev_fair  = 1'b0;
    end else begin
      both   = (|i_dir_wd_irq) & (|i_ldb_wd_irq);
      xfer   = i_req_valid & i_req_ready;
      onehot = NQ'(1) << i_req.cq;
      if (prev_stall && !i_req_valid) begin
        plain_error("request dropped while ready was low");
      end else if (prev_stall && i_req !== prev_req) begin
        value_error("o_req", i_req, prev_req);  // Must hold under back-pressure
      end
      if (xfer) begin
        if (i_req.is_ldb) ldb_cnt[i_req.cq]++;
        else              dir_cnt[i_req.cq]++;
        if (i_dir_wdto_v !== !i_req.is_ldb) begin
          value_error("o_dir_wdto_v", i_dir_wdto_v, !i_req.is_ldb);
        end
        if (i_ldb_wdto_v !== i_req.is_ldb) begin
          value_error("o_ldb_wdto_v", i_ldb_wdto_v, i_req.is_ldb);
        end
        if (i_dir_wdto_nxt !== (i_req.is_ldb ? '0 : onehot[`WD_DIR_NUM_CQ-1:0])) begin
          value_error("o_dir_wdto_nxt", i_dir_wdto_nxt,
                      i_req.is_ldb ? '0 : onehot[`WD_DIR_NUM_CQ-1:0]);
        end
        if (i_ldb_wdto_nxt !== (i_req.is_ldb ? onehot[`WD_LDB_NUM_CQ-1:0] : '0)) begin
          value_error("o_ldb_wdto_nxt", i_ldb_wdto_nxt,
                      i_req.is_ldb ? onehot[`WD_LDB_NUM_CQ-1:0] : '0);
        end
        // Loaded while both classes pending, so class must alternate
        if (prev_fair && i_req.is_ldb == prev_req.is_ldb) begin
          plain_error("same class reported twice in a row while the other class was pending");
        end
      end else if (i_dir_wdto_v || i_ldb_wdto_v) begin
        plain_error("timeout report strobe without a transfer");
      end
      prev_stall = i_req_valid & ~i_req_ready;
      prev_fair  = xfer & both;
      prev_req   = i_req;
    end
  end

endmodule

//--- source/chp_wd_top.sv
`timescale 1ns/100ps
`include "wd_params.svh"

module chp_wd_top (
   input  logic                       hqm_gated_clk
  ,input  logic                       hqm_gated_rst_n

  // dir class
  ,input  wd_pkg::wd_cfg_t            i_dir_cfg
  ,input  logic                       i_dir_cfg_update_v
  ,input  logic [`WD_DIR_NUM_CQ-1:0]  i_dir_cq_wd_en
  ,input  logic [`WD_DIR_NUM_CQ-1:0]  i_dir_cq_busy
  ,input  wd_pkg::cq_event_t          i_dir_excep
  ,output logic [`WD_DIR_NUM_CQ-1:0]  o_dir_wd_irq
  ,output logic                       o_dir_wdto_v
  ,output logic [`WD_DIR_NUM_CQ-1:0]  o_dir_wdto_nxt

  // ldb class
  ,input  wd_pkg::wd_cfg_t            i_ldb_cfg
  ,input  logic                       i_ldb_cfg_update_v
  ,input  logic [`WD_LDB_NUM_CQ-1:0]  i_ldb_cq_wd_en
  ,input  logic [`WD_LDB_NUM_CQ-1:0]  i_ldb_cq_busy
  ,input  wd_pkg::cq_event_t          i_ldb_excep
  ,output logic [`WD_LDB_NUM_CQ-1:0]  o_ldb_wd_irq
  ,output logic                       o_ldb_wdto_v
  ,output logic [`WD_LDB_NUM_CQ-1:0]  o_ldb_wdto_nxt

  // Interrupt request
  ,input  logic                       i_req_ready
  ,output logic                       o_req_valid
  ,output wd_pkg::cwdi_req_t          o_req
);

  logic                     dir_winner_v;
  logic [`WD_CQ_IDX_W-1:0]  dir_winner;
  logic                     dir_update;
  logic                     ldb_winner_v;
  logic [`WD_CQ_IDX_W-1:0]  ldb_winner;
  logic                     ldb_update;

  // ----------------------------------------------------------------------
  // Per-class watchdogs
  // ----------------------------------------------------------------------
  cq_watchdog #(
    .NUM_CQ (`WD_DIR_NUM_CQ)
  ) dir_wd (
     .hqm_gated_clk   (hqm_gated_clk)
    ,.hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_cfg           (i_dir_cfg)
    ,.i_cfg_update_v  (i_dir_cfg_update_v)
    ,.i_cq_wd_en      (i_dir_cq_wd_en)
    ,.i_cq_busy       (i_dir_cq_busy)
    ,.i_excep         (i_dir_excep)
    ,.i_update        (dir_update)
    ,.o_irq           (o_dir_wd_irq)
    ,.o_winner_v      (dir_winner_v)
    ,.o_winner        (dir_winner)
  );

  cq_watchdog #(
    .NUM_CQ (`WD_LDB_NUM_CQ)
  ) ldb_wd (
     .hqm_gated_clk   (hqm_gated_clk)
    ,.hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_cfg           (i_ldb_cfg)
    ,.i_cfg_update_v  (i_ldb_cfg_update_v)
    ,.i_cq_wd_en      (i_ldb_cq_wd_en)
    ,.i_cq_busy       (i_ldb_cq_busy)
    ,.i_excep         (i_ldb_excep)
    ,.i_update        (ldb_update)
    ,.o_irq           (o_ldb_wd_irq)
    ,.o_winner_v      (ldb_winner_v)
    ,.o_winner        (ldb_winner)
  );

  // Class arbitration and request register
  wd_irq_report irq_report (
     .hqm_gated_clk   (hqm_gated_clk)
    ,.hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_dir_winner_v  (dir_winner_v)
    ,.i_dir_winner    (dir_winner)
    ,.i_ldb_winner_v  (ldb_winner_v)
    ,.i_ldb_winner    (ldb_winner)
    ,.i_req_ready     (i_req_ready)
    ,.o_dir_update    (dir_update)
    ,.o_ldb_update    (ldb_update)
    ,.o_req_valid     (o_req_valid)
    ,.o_req           (o_req)
    ,.o_dir_wdto_v    (o_dir_wdto_v)
    ,.o_dir_wdto_nxt  (o_dir_wdto_nxt)
    ,.o_ldb_wdto_v    (o_ldb_wdto_v)
    ,.o_ldb_wdto_nxt  (o_ldb_wdto_nxt)
  );

endmodule

//--- source/wd_irq_report.sv
`timescale 1ns/100ps
`include "wd_params.svh"

module wd_irq_report (
   input  logic                       hqm_gated_clk
  ,input  logic                       hqm_gated_rst_n

  ,input  logic                       i_dir_winner_v
  ,input  logic [`WD_CQ_IDX_W-1:0]    i_dir_winner
  ,input  logic                       i_ldb_winner_v
  ,input  logic [`WD_CQ_IDX_W-1:0]    i_ldb_winner
  ,input  logic                       i_req_ready

  ,output logic                       o_dir_update
  ,output logic                       o_ldb_update
  ,output logic                       o_req_valid
  ,output wd_pkg::cwdi_req_t          o_req

  ,output logic                       o_dir_wdto_v
  ,output logic [`WD_DIR_NUM_CQ-1:0]  o_dir_wdto_nxt
  ,output logic                       o_ldb_wdto_v
  ,output logic [`WD_LDB_NUM_CQ-1:0]  o_ldb_wdto_nxt
);

  import wd_pkg::*;

  localparam int ONEHOT_W = 1 << `WD_CQ_IDX_W;

  cwdi_req_t           req_f;
  cwdi_req_t           req_nxt;
  logic                req_valid_f;
  logic                req_valid_nxt;
  logic                xfer;
  logic                cls_update;
  logic                cls_winner_v;
  logic                cls_winner;    // 0 dir, 1 ldb
  logic [ONEHOT_W-1:0] cq_onehot;

  // Second stage keeps dir and ldb alternating
  wd_rr_arb #(
    .NUM_REQS (2)
  ) cls_arb (
     .hqm_gated_clk   (hqm_gated_clk)
    ,.hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_reqs          ({i_ldb_winner_v, i_dir_winner_v})
    ,.i_update        (cls_update)
    ,.o_winner_v      (cls_winner_v)
    ,.o_winner        (cls_winner)
  );

  assign xfer = req_valid_f & i_req_ready;

  // ----------------------------------------------------------------------
  // Request register load
  // ----------------------------------------------------------------------
  always_comb begin
    req_valid_nxt  = req_valid_f;
    cls_update     = 1'b0;
    o_dir_update   = 1'b0;
    o_ldb_update   = 1'b0;
    req_nxt.is_ldb = cls_winner;
    req_nxt.cq     = cls_winner ? i_ldb_winner : i_dir_winner;

    // Take one winner when the slot is empty or draining
    if (cls_winner_v & (~req_valid_f | xfer)) begin
      cls_update    = 1'b1;
      o_ldb_update  = cls_winner;
      o_dir_update  = ~cls_winner;
      req_valid_nxt = 1'b1;
    end else if (xfer) begin
      req_valid_nxt = 1'b0;
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (~hqm_gated_rst_n) begin
      req_valid_f <= 1'b0;
    end else begin
      req_valid_f <= req_valid_nxt;
    end
  end

  // Held while stalled, so o_req is stable under back-pressure
  always_ff @(posedge hqm_gated_clk) begin
    if (cls_update) begin
      req_f <= req_nxt;
    end
  end

  assign o_req_valid = req_valid_f;
  assign o_req       = req_f;

  // ----------------------------------------------------------------------
  // Timeout report on transfer
  // ----------------------------------------------------------------------
  assign o_dir_wdto_v = xfer & ~req_f.is_ldb;
  assign o_ldb_wdto_v = xfer & req_f.is_ldb;

  assign cq_onehot = ONEHOT_W'(1) << req_f.cq;

  assign o_dir_wdto_nxt = cq_onehot[`WD_DIR_NUM_CQ-1:0] & {`WD_DIR_NUM_CQ{o_dir_wdto_v}};
  assign o_ldb_wdto_nxt = cq_onehot[`WD_LDB_NUM_CQ-1:0] & {`WD_LDB_NUM_CQ{o_ldb_wdto_v}};

endmodule

//--- source/cq_watchdog.sv
`timescale 1ns/100ps
`include "wd_params.svh"

module cq_watchdog #(
  parameter int NUM_CQ = 8
) (
   input  logic                      hqm_gated_clk
  ,input  logic                      hqm_gated_rst_n

  ,input  wd_pkg::wd_cfg_t           i_cfg
  ,input  logic                      i_cfg_update_v
  ,input  logic [NUM_CQ-1:0]         i_cq_wd_en
  ,input  logic [NUM_CQ-1:0]         i_cq_busy
  ,input  wd_pkg::cq_event_t         i_excep

  ,input  logic                      i_update   // Winner taken by report stage
  ,output logic [NUM_CQ-1:0]         o_irq
  ,output logic                      o_winner_v
  ,output logic [`WD_CQ_IDX_W-1:0]   o_winner
);

  import wd_pkg::*;

  localparam int IDX_W = `WD_CQ_IDX_W;
  localparam int ARB_N = (NUM_CQ > 1) ? NUM_CQ : 2;  // Arbiter needs two inputs
  localparam int ARB_W = $clog2(ARB_N);

  wd_cfg_t                    cfg_f;
  logic [`WD_INTERVAL_W-1:0]  ivl_cnt_f;
  logic [`WD_INTERVAL_W-1:0]  ivl_last;
  logic                       tick;

  logic [NUM_CQ-1:0]          act_f;
  logic [NUM_CQ-1:0]          act_now;
  logic [NUM_CQ-1:0]          pend_f;
  logic [NUM_CQ-1:0]          pend_nxt;
  logic [`WD_THRESHOLD_W-1:0] cnt_f   [NUM_CQ];
  logic [`WD_THRESHOLD_W-1:0] cnt_nxt [NUM_CQ];

  logic [ARB_N-1:0]           arb_reqs;
  logic [ARB_W-1:0]           arb_winner;

  // ----------------------------------------------------------------------
  // Configuration and interval timer
  // ----------------------------------------------------------------------
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (~hqm_gated_rst_n) begin
      cfg_f <= '0;
    end else if (i_cfg_update_v) begin
      cfg_f <= i_cfg;
    end
  end

  // Zero interval ticks every cycle
  assign ivl_last = (cfg_f.interval == '0) ? '0 : cfg_f.interval - 1'b1;
  assign tick     = (ivl_cnt_f >= ivl_last);

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (~hqm_gated_rst_n) begin
      ivl_cnt_f <= '0;
    end else if (i_cfg_update_v | tick) begin
      ivl_cnt_f <= '0;  // Strobe restarts the interval
    end else begin
      ivl_cnt_f <= ivl_cnt_f + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Activity since last tick
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_CQ; i++) begin
      act_now[i] = act_f[i] | (i_excep.v & (int'(i_excep.cq) == i));
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (~hqm_gated_rst_n) begin
      act_f <= '0;
    end else if (tick) begin
      act_f <= '0;  // Consumed by this tick
    end else begin
      act_f <= act_now;
    end
  end

  // ----------------------------------------------------------------------
  // Per-CQ counts and pending bits
  // ----------------------------------------------------------------------
  always_comb begin
    logic [`WD_THRESHOLD_W-1:0] inc;
    for (int i = 0; i < NUM_CQ; i++) begin
      cnt_nxt[i]  = cnt_f[i];
      pend_nxt[i] = pend_f[i];
      inc         = cnt_f[i] + 1'b1;

      // Granted by the report stage
      if (i_update & (int'(arb_winner) == i)) begin
        pend_nxt[i] = 1'b0;
      end

      // A pending CQ stops counting until granted
      if (tick & ~pend_f[i]) begin
        if (act_now[i] | ~i_cq_busy[i] | ~i_cq_wd_en[i]) begin
          cnt_nxt[i] = '0;
        end else if (inc == cfg_f.threshold) begin
          cnt_nxt[i]  = '0;
          pend_nxt[i] = 1'b1;
        end else begin
          cnt_nxt[i] = inc;
        end
      end
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (~hqm_gated_rst_n) begin
      cnt_f  <= '{default: '0};
      pend_f <= '0;
    end else begin
      cnt_f  <= cnt_nxt;
      pend_f <= pend_nxt;
    end
  end

  assign o_irq = pend_f;

  // Class arbiter over the pending bits
  assign arb_reqs = ARB_N'(pend_f);

  wd_rr_arb #(
    .NUM_REQS (ARB_N)
  ) cq_arb (
     .hqm_gated_clk   (hqm_gated_clk)
    ,.hqm_gated_rst_n (hqm_gated_rst_n)
    ,.i_reqs          (arb_reqs)
    ,.i_update        (i_update)
    ,.o_winner_v      (o_winner_v)
    ,.o_winner        (arb_winner)
  );

  assign o_winner = IDX_W'(arb_winner);

endmodule

//--- source/wd_rr_arb.sv
`timescale 1ns/100ps

module wd_rr_arb #(
  parameter int NUM_REQS = 4
) (
   input  logic                        hqm_gated_clk
  ,input  logic                        hqm_gated_rst_n
  ,input  logic [NUM_REQS-1:0]         i_reqs
  ,input  logic                        i_update
  ,output logic                        o_winner_v
  ,output logic [$clog2(NUM_REQS)-1:0] o_winner
);

  localparam int W = $clog2(NUM_REQS);

  logic [W-1:0] last_f;  // Index granted most recently

  // Rotating priority search starting one past last_f
  always_comb begin
    int idx;
    o_winner_v = 1'b0;
    o_winner   = '0;
    // Walk from the far end so the nearest requester is kept
    for (int off = NUM_REQS; off >= 1; off--) begin
      idx = (int'(last_f) + off) % NUM_REQS;
      if (i_reqs[idx]) begin
        o_winner_v = 1'b1;
        o_winner   = W'(idx);
      end
    end
  end

  // Pointer only moves when the winner is actually taken
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (~hqm_gated_rst_n) begin
      last_f <= W'(NUM_REQS - 1);  // Index 0 first after reset
    end else if (i_update & o_winner_v) begin
      last_f <= o_winner;
    end
  end

endmodule

//--- source/wd_pkg.sv
`include "wd_params.svh"

package wd_pkg;

  // Per-class timer configuration
  typedef struct packed {
    logic [`WD_INTERVAL_W-1:0]  interval;   // Zero behaves as one
    logic [`WD_THRESHOLD_W-1:0] threshold;
  } wd_cfg_t;

  // Enqueue or schedule activity on one CQ
  typedef struct packed {
    logic                    v;
    logic [`WD_CQ_IDX_W-1:0] cq;
  } cq_event_t;

  // Watchdog interrupt request toward the interrupt block
  typedef struct packed {
    logic                    is_ldb;  // 0 dir, 1 ldb
    logic [`WD_CQ_IDX_W-1:0] cq;
  } cwdi_req_t;

endpackage

//--- source/wd_params.svh
`ifndef WD_PARAMS_SVH
`define WD_PARAMS_SVH

// ----------------------------------------------------------------------
// CQ counts per class
// ----------------------------------------------------------------------
`define WD_DIR_NUM_CQ   8
`define WD_LDB_NUM_CQ   16

// Covers the larger of the two classes
`define WD_CQ_IDX_W     4

// ----------------------------------------------------------------------
// Timer widths
// ----------------------------------------------------------------------
`define WD_INTERVAL_W   12   // Cycles per tick
`define WD_THRESHOLD_W  8    // Ticks to fire and per-CQ count width

`endif
